// File: stcIoPkg.sv
`default_nettype none

package stcIoPkg;

    // ************************************************************************
    // Bus and data types
    // ************************************************************************

    typedef logic [31:0] busData_t;

    // One processor bus cycle, already in the clk domain
    typedef struct packed {
        logic        cs;
        logic        rd;
        logic [3:0]  wrEn;          // Byte lanes
        logic [11:0] addr;          // Byte address
        busData_t    wrData;
    } regBus_t;

    typedef logic signed [17:0] sample_t;
    typedef logic [13:0]        dacWord_t;     // Offset binary
    typedef logic [13:0]        adcWord_t;     // Offset binary
    typedef logic [1:0]         vidSelect_t;

    // Code 3 is unassigned and plays out as zero
    typedef enum logic [1:0] {
        SrcZero = 2'd0,
        SrcAdc  = 2'd1,
        SrcTest = 2'd2
    } dacSource_t;

    // ************************************************************************
    // Address map
    // ************************************************************************

    // Compared against addr[11:4]
    localparam logic [7:0] SpaceTop   = 8'h00;
    localparam logic [7:0] SpaceVideo = 8'h01;
    localparam logic [7:0] SpaceDac0  = 8'h10;    // Channel n at SpaceDac0 + n

    // Word index in addr[3:2]
    localparam logic [1:0] OffVersion   = 2'd0;
    localparam logic [1:0] OffScratch   = 2'd1;
    localparam logic [1:0] OffAdcStatus = 2'd2;
    localparam logic [1:0] OffDacSource = 2'd0;
    localparam logic [1:0] OffDacTest   = 2'd1;
    localparam logic [1:0] OffVid0      = 2'd0;
    localparam logic [1:0] OffVid1      = 2'd1;

    localparam dacWord_t DacMidscale = 14'h2000;

    // Merge the enabled write bytes into a register word
    function automatic busData_t applyLanes(busData_t cur, busData_t wrData,
                                            logic [3:0] lanes);
        busData_t result;
        result = cur;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                result[8*b +: 8] = wrData[8*b +: 8];
            end
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// File: regDecode.sv
`default_nettype none

module regDecode #(
    parameter int NumDacs = 2
) (
    input  stcIoPkg::regBus_t                bus,
    input  stcIoPkg::busData_t               topRd,
    input  stcIoPkg::busData_t               videoRd,
    input  stcIoPkg::busData_t [NumDacs-1:0] dacRd,
    output logic                             topSel,
    output logic                             videoSel,
    output logic [NumDacs-1:0]               dacSel,
    output stcIoPkg::busData_t               rdData
);
    import stcIoPkg::*;

    logic [7:0] space;

    assign space = bus.addr[11:4];

    // Space selects, qualified by chip select
    always_comb begin
        topSel   = bus.cs && (space == SpaceTop);
        videoSel = bus.cs && (space == SpaceVideo);
        for (int n = 0; n < NumDacs; n++) begin
            dacSel[n] = bus.cs && (space == SpaceDac0 + 8'(n));
        end
    end

    // Read data mux
    always_comb begin
        rdData = '0;                // Unmapped or idle reads return zero
        if (bus.rd) begin
            if (topSel) begin
                rdData = topRd;
            end
            if (videoSel) begin
                rdData = videoRd;
            end
            for (int n = 0; n < NumDacs; n++) begin
                if (dacSel[n]) begin
                    rdData = dacRd[n];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: topRegs.sv
`default_nettype none

module topRegs #(
    parameter logic [15:0] VersionNumber = 16'd671
) (
    input  logic               clk,
    input  logic               rst,
    input  stcIoPkg::regBus_t  bus,
    input  logic               sel,
    input  logic               adcOverflow,
    output stcIoPkg::busData_t rdData,
    output logic               overflowClear
);
    import stcIoPkg::*;

    busData_t   scratch;
    logic       wrHit;
    logic [1:0] offset;

    assign wrHit  = sel && (|bus.wrEn);
    assign offset = bus.addr[3:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            scratch       <= '0;
            overflowClear <= 1'b0;
        end else begin
            if (wrHit && (offset == OffScratch)) begin
                scratch <= applyLanes(scratch, bus.wrData, bus.wrEn);
            end
            // Write 1 to status bit 0 clears the sticky flag
            overflowClear <= wrHit && (offset == OffAdcStatus)
                             && bus.wrEn[0] && bus.wrData[0];
        end
    end

    always_comb begin
        case (offset)
            OffVersion:   rdData = {16'h0000, VersionNumber};   // Read only
            OffScratch:   rdData = scratch;
            OffAdcStatus: rdData = {31'b0, adcOverflow};
            default:      rdData = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: adcFrontEnd.sv
`default_nettype none

module adcFrontEnd (
    input  logic               clk,
    input  logic               rst,
    input  stcIoPkg::adcWord_t adc0,
    input  logic               adc0Overflow,
    input  logic               overflowClear,
    output stcIoPkg::sample_t  adcSample,
    output logic               adcOverflow
);
    import stcIoPkg::*;

    adcWord_t adcReg;

    // Reclock, then offset binary to signed, left justified in 18 bits
    always_ff @(posedge clk) begin
        adcReg    <= adc0;
        adcSample <= $signed({~adcReg[13], adcReg[12:0], 4'b0000});
    end

    // Sticky overflow flag
    always_ff @(posedge clk) begin
        if (rst) begin
            adcOverflow <= 1'b0;
        end else if (overflowClear) begin
            adcOverflow <= 1'b0;        // Clear beats a simultaneous set
        end else if (adc0Overflow) begin
            adcOverflow <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: dacRegs.sv
`default_nettype none

module dacRegs (
    input  logic                 clk,
    input  logic                 rst,
    input  stcIoPkg::regBus_t    bus,
    input  logic                 sel,
    output stcIoPkg::busData_t   rdData,
    output stcIoPkg::dacSource_t source,
    output stcIoPkg::sample_t    testValue
);
    import stcIoPkg::*;

    logic       wrHit;
    logic [1:0] offset;
    busData_t   sourceWord;
    busData_t   testWord;
    busData_t   srcMerged;
    busData_t   testMerged;

    assign wrHit      = sel && (|bus.wrEn);
    assign offset     = bus.addr[3:2];
    assign sourceWord = {30'b0, source};
    assign testWord   = {14'b0, testValue};       // Reads back zero extended
    assign srcMerged  = applyLanes(sourceWord, bus.wrData, bus.wrEn);
    assign testMerged = applyLanes(testWord, bus.wrData, bus.wrEn);

    always_ff @(posedge clk) begin
        if (rst) begin
            source    <= SrcZero;
            testValue <= '0;
        end else if (wrHit) begin
            if (offset == OffDacSource) begin
                source <= dacSource_t'(srcMerged[1:0]);
            end
            if (offset == OffDacTest) begin
                testValue <= $signed(testMerged[17:0]);
            end
        end
    end

    always_comb begin
        case (offset)
            OffDacSource: rdData = sourceWord;
            OffDacTest:   rdData = testWord;
            default:      rdData = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: dacChannel.sv
`default_nettype none

module dacChannel (
    input  logic                 clk,
    input  logic                 rst,
    input  stcIoPkg::dacSource_t source,
    input  stcIoPkg::sample_t    testValue,
    input  stcIoPkg::sample_t    adcSample,
    output stcIoPkg::dacWord_t   dacData
);
    import stcIoPkg::*;

    sample_t selSample;

    always_ff @(posedge clk) begin
        if (rst) begin
            selSample <= '0;
            dacData   <= DacMidscale;
        end else begin
            case (source)
                SrcAdc:  selSample <= adcSample;
                SrcTest: selSample <= testValue;
                default: selSample <= '0;           // Zero and unused code 3
            endcase
            // Back to offset binary, top 14 bits
            dacData <= {~selSample[17], selSample[16:4]};
        end
    end

endmodule

`default_nettype wire

// File: videoSwitch.sv
`default_nettype none

module videoSwitch (
    input  logic                 clk,
    input  logic                 rst,
    input  stcIoPkg::regBus_t    bus,
    input  logic                 sel,
    output stcIoPkg::busData_t   rdData,
    output stcIoPkg::vidSelect_t video0InSelect,
    output stcIoPkg::vidSelect_t video0OutSelect,
    output stcIoPkg::vidSelect_t video1InSelect,
    output stcIoPkg::vidSelect_t video1OutSelect
);
    import stcIoPkg::*;

    vidSelect_t vid0;
    vidSelect_t vid1;
    logic [1:0] offset;

    // Out select lines are crossed on the board, 01 and 10 trade places.
    // For a 2-bit code that is a plain bit reversal.
    function automatic vidSelect_t layoutSwap(vidSelect_t code);
        return {code[0], code[1]};
    endfunction

    assign offset = bus.addr[3:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            vid0 <= '0;
            vid1 <= '0;
        end else if (sel && bus.wrEn[0]) begin     // Code lives in byte 0
            if (offset == OffVid0) begin
                vid0 <= bus.wrData[1:0];
            end
            if (offset == OffVid1) begin
                vid1 <= bus.wrData[1:0];
            end
        end
    end

    assign video0InSelect  = vid0;
    assign video1InSelect  = vid1;
    assign video0OutSelect = layoutSwap(vid0);
    assign video1OutSelect = layoutSwap(vid1);

    always_comb begin
        case (offset)
            OffVid0: rdData = {30'b0, vid0};
            OffVid1: rdData = {30'b0, vid1};
            default: rdData = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: stcIoTop.sv
`default_nettype none

module stcIoTop #(
    parameter logic [15:0] VersionNumber = 16'd671,
    parameter int          NumDacs       = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  stcIoPkg::regBus_t    bus,
    output stcIoPkg::busData_t   rdData,
    input  stcIoPkg::adcWord_t   adc0,
    input  logic                 adc0Overflow,
    output stcIoPkg::dacWord_t   dac0Data,
    output stcIoPkg::dacWord_t   dac1Data,
    output stcIoPkg::vidSelect_t video0InSelect,
    output stcIoPkg::vidSelect_t video0OutSelect,
    output stcIoPkg::vidSelect_t video1InSelect,
    output stcIoPkg::vidSelect_t video1OutSelect
);
    import stcIoPkg::*;

    logic                   topSel;
    logic                   videoSel;
    logic [NumDacs-1:0]     dacSel;
    busData_t               topRd;
    busData_t               videoRd;
    busData_t [NumDacs-1:0] dacRd;
    sample_t                adcSample;
    logic                   adcOverflow;
    logic                   overflowClear;
    dacWord_t [NumDacs-1:0] dacData;

    // ************************************************************************
    // Register bus
    // ************************************************************************

    regDecode #(.NumDacs(NumDacs)) uDecode (
        .bus(bus), .topRd(topRd), .videoRd(videoRd), .dacRd(dacRd),
        .topSel(topSel), .videoSel(videoSel), .dacSel(dacSel),
        .rdData(rdData)
    );

    topRegs #(.VersionNumber(VersionNumber)) uTopRegs (
        .clk(clk), .rst(rst), .bus(bus), .sel(topSel),
        .adcOverflow(adcOverflow), .rdData(topRd),
        .overflowClear(overflowClear)
    );

    videoSwitch uVideo (
        .clk(clk), .rst(rst), .bus(bus), .sel(videoSel), .rdData(videoRd),
        .video0InSelect(video0InSelect), .video0OutSelect(video0OutSelect),
        .video1InSelect(video1InSelect), .video1OutSelect(video1OutSelect)
    );

    // ************************************************************************
    // Data path
    // ************************************************************************

    adcFrontEnd uAdc (
        .clk(clk), .rst(rst), .adc0(adc0), .adc0Overflow(adc0Overflow),
        .overflowClear(overflowClear), .adcSample(adcSample),
        .adcOverflow(adcOverflow)
    );

    for (genvar i = 0; i < NumDacs; i++) begin : gDac
        dacSource_t source;
        sample_t    testValue;

        dacRegs uRegs (
            .clk(clk), .rst(rst), .bus(bus), .sel(dacSel[i]),
            .rdData(dacRd[i]), .source(source), .testValue(testValue)
        );

        dacChannel uChan (
            .clk(clk), .rst(rst), .source(source), .testValue(testValue),
            .adcSample(adcSample), .dacData(dacData[i])
        );
    end

    assign dac0Data = dacData[0];
    assign dac1Data = dacData[1];

endmodule

`default_nettype wire

// File: stcIoTop_assertions.sv
`default_nettype none

module stcIoTopAssertions #(
    parameter int NumDacs = 2
) (
    input wire logic                 clk,
    input wire logic                 rst,
    input wire logic                 topSel,
    input wire logic                 videoSel,
    input wire logic [NumDacs-1:0]   dacSel,
    input wire stcIoPkg::vidSelect_t video0InSelect,
    input wire stcIoPkg::vidSelect_t video0OutSelect,
    input wire stcIoPkg::vidSelect_t video1InSelect,
    input wire stcIoPkg::vidSelect_t video1OutSelect,
    input wire stcIoPkg::dacWord_t   dac0Data
);
    import stcIoPkg::*;

    int failCount = 0;      // Read by the testbench summary

    function automatic vidSelect_t swapped(vidSelect_t code);
        return (code == 2'b01) ? 2'b10 : ((code == 2'b10) ? 2'b01 : code);
    endfunction

    oneSpace: assert property (@(posedge clk) disable iff (rst)
        $countones({topSel, videoSel, dacSel}) <= 1)
        else begin
            $error("More than one address space selected");
            failCount++;
        end

    outSwap: assert property (@(posedge clk) disable iff (rst)
        (video0OutSelect == swapped(video0InSelect))
        && (video1OutSelect == swapped(video1InSelect)))
        else begin
            $error("Video out select is not the swapped in select");
            failCount++;
        end

    // First cycle out of reset
    midscaleAfterReset: assert property (@(posedge clk)
        $fell(rst) |-> dac0Data == DacMidscale)
        else begin
            $error("dac0Data not at midscale after reset");
            failCount++;
        end

endmodule

bind stcIoTop stcIoTopAssertions #(.NumDacs(NumDacs)) uChecks (
    .clk(clk), .rst(rst), .topSel(topSel), .videoSel(videoSel), .dacSel(dacSel),
    .video0InSelect(video0InSelect), .video0OutSelect(video0OutSelect),
    .video1InSelect(video1InSelect), .video1OutSelect(video1OutSelect),
    .dac0Data(dac0Data)
);

`default_nettype wire

// File: stcIoTop_tb.sv
`default_nettype none

module stcIoTop_tb;
    import stcIoPkg::*;

    localparam int ClkPeriod     = 40;
    localparam int NumTests      = 6;
    localparam int CyclesPerTest = 200;
    localparam int AdcWords      = 64;

    logic       clk;
    logic       rst;
    regBus_t    bus;
    busData_t   rdData;
    adcWord_t   adc0;
    logic       adc0Overflow;
    dacWord_t   dac0Data;
    dacWord_t   dac1Data;
    vidSelect_t video0InSelect;
    vidSelect_t video0OutSelect;
    vidSelect_t video1InSelect;
    vidSelect_t video1OutSelect;

    logic [31:0] lfsrState = 32'h117b;
    string       currentTest;
    int          testErrors  = 0;
    int          totalErrors = 0;
    int          testsRun    = 0;
    int          testsFailed = 0;

    stcIoTop #(.VersionNumber(16'd671), .NumDacs(2)) UUT (
        .clk(clk), .rst(rst), .bus(bus), .rdData(rdData),
        .adc0(adc0), .adc0Overflow(adc0Overflow),
        .dac0Data(dac0Data), .dac1Data(dac1Data),
        .video0InSelect(video0InSelect), .video0OutSelect(video0OutSelect),
        .video1InSelect(video1InSelect), .video1OutSelect(video1OutSelect)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // Whole run gets a fixed cycle budget per test
    initial begin
        #(ClkPeriod * (CyclesPerTest * NumTests + 8 + 100));
        $display("Watchdog expired, the tests did not complete in time");
        $display("Test failures found");
        $finish;
    end

    // ************************************************************************
    // Helpers
    // ************************************************************************

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsrBit()};
        end
        return value;
    endfunction

    function automatic logic [11:0] regAddr(logic [7:0] space, logic [1:0] offset);
        return {space, offset, 2'b00};
    endfunction

    // Expected DAC formatting: flip sign bit, keep the top 14 bits
    function automatic dacWord_t sampleToDac(sample_t s);
        return {~s[17], s[16:4]};
    endfunction

    function automatic vidSelect_t swapCode(vidSelect_t code);
        case (code)
            2'b01:   return 2'b10;
            2'b10:   return 2'b01;
            default: return code;
        endcase
    endfunction

    task automatic reportMismatch(string what, logic [31:0] expected, logic [31:0] actual);
        $display("[ERROR] %s %s expected 0x%0h actual 0x%0h",
                 currentTest, what, expected, actual);
        testErrors++;
    endtask

    task automatic startTest(string name);
        currentTest = name;
        testErrors  = 0;
    endtask

    task automatic finishTest();
        testsRun++;
        totalErrors += testErrors;
        if (testErrors == 0) begin
            $display("%s: done, no errors", currentTest);
        end else begin
            testsFailed++;
            $display("%s: done, %0d errors", currentTest, testErrors);
        end
    endtask

    task automatic busWrite(logic [11:0] address, busData_t data, logic [3:0] lanes);
        @(posedge clk);
        bus <= '{cs: 1'b1, rd: 1'b0, wrEn: lanes, addr: address, wrData: data};
        @(posedge clk);                 // Register captures here
        bus <= '0;
    endtask

    task automatic busRead(logic [11:0] address, output busData_t data);
        @(posedge clk);
        bus <= '{cs: 1'b1, rd: 1'b1, wrEn: 4'b0000, addr: address, wrData: '0};
        @(negedge clk);
        data = rdData;                  // Combinational read, stable mid cycle
        @(posedge clk);
        bus <= '0;
    endtask

    // ************************************************************************
    // Tests
    // ************************************************************************

    task automatic testResetState();
        busData_t value;
        startTest("resetState");
        if (dac0Data !== 14'h2000) reportMismatch("dac0Data", 32'h2000, 32'(dac0Data));
        if (dac1Data !== 14'h2000) reportMismatch("dac1Data", 32'h2000, 32'(dac1Data));
        if ({video0InSelect, video0OutSelect, video1InSelect, video1OutSelect} !== 8'h00) begin
            reportMismatch("videoSelects", 32'h0,
                32'({video0InSelect, video0OutSelect, video1InSelect, video1OutSelect}));
        end
        busRead(regAddr(SpaceTop, OffScratch), value);
        if (value !== 32'h0) reportMismatch("scratch", 32'h0, value);
        busRead(12'h200, value);        // Space 0x20 is unmapped
        if (value !== 32'h0) reportMismatch("unmapped", 32'h0, value);
        finishTest();
    endtask

    task automatic testTopRegs();
        busData_t    value;
        busData_t    expected;
        busData_t    data;
        logic [31:0] r;
        logic [3:0]  lanes;
        startTest("topRegs");
        busWrite(regAddr(SpaceTop, OffVersion), 32'hffff_ffff, 4'b1111);   // Read only
        busRead(regAddr(SpaceTop, OffVersion), value);
        if (value !== 32'd671) reportMismatch("version", 32'd671, value);
        expected = '0;
        for (int i = 0; i < 8; i++) begin
            data  = randBits(32);
            r     = randBits(4);
            lanes = r[3:0];
            for (int b = 0; b < 4; b++) begin
                if (lanes[b]) begin
                    expected[8*b +: 8] = data[8*b +: 8];
                end
            end
            busWrite(regAddr(SpaceTop, OffScratch), data, lanes);
            busRead(regAddr(SpaceTop, OffScratch), value);
            if (value !== expected) reportMismatch("scratch", expected, value);
        end
        finishTest();
    endtask

    task automatic testAdcPath();
        adcWord_t    sent[$];
        dacWord_t    expDac;
        logic [31:0] r;
        startTest("adcPath");
        busWrite(regAddr(SpaceDac0, OffDacSource), 32'(SrcAdc), 4'b0001);
        busWrite(regAddr(SpaceDac0 + 8'd1, OffDacSource), 32'(SrcAdc), 4'b0001);
        for (int j = 0; j < AdcWords + 4; j++) begin
            r = randBits(14);
            @(posedge clk);
            adc0 <= r[13:0];
            sent.push_back(r[13:0]);
            @(negedge clk);
            if (j >= 4) begin           // Word from 4 edges back
                expDac = sent.pop_front();      // MSB flipped twice, word comes back as sent
                if (dac0Data !== expDac) reportMismatch("dac0Data", 32'(expDac), 32'(dac0Data));
                if (dac1Data !== expDac) reportMismatch("dac1Data", 32'(expDac), 32'(dac1Data));
            end
        end
        finishTest();
    endtask

    task automatic testTestSource();
        sample_t     t0;
        sample_t     t1;
        busData_t    value;
        logic [31:0] r;
        startTest("testSource");
        r  = randBits(18);
        t0 = r[17:0];
        r  = randBits(18);
        t1 = r[17:0];
        busWrite(regAddr(SpaceDac0, OffDacSource), 32'(SrcTest), 4'b0001);
        busWrite(regAddr(SpaceDac0 + 8'd1, OffDacSource), 32'(SrcTest), 4'b0001);
        busWrite(regAddr(SpaceDac0, OffDacTest), {14'b0, t0}, 4'b1111);
        busWrite(regAddr(SpaceDac0 + 8'd1, OffDacTest), {14'b0, t1}, 4'b1111);
        repeat (2) @(posedge clk);      // Third edge after the write
        @(negedge clk);
        if (dac0Data !== sampleToDac(t0)) begin
            reportMismatch("dac0Data", 32'(sampleToDac(t0)), 32'(dac0Data));
        end
        if (dac1Data !== sampleToDac(t1)) begin
            reportMismatch("dac1Data", 32'(sampleToDac(t1)), 32'(dac1Data));
        end
        busRead(regAddr(SpaceDac0, OffDacTest), value);
        if (value !== {14'b0, t0}) reportMismatch("testValue0", {14'b0, t0}, value);
        // Unused source code plays out as zero
        busWrite(regAddr(SpaceDac0, OffDacSource), 32'd3, 4'b0001);
        busWrite(regAddr(SpaceDac0 + 8'd1, OffDacSource), 32'd3, 4'b0001);
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (dac0Data !== 14'h2000) reportMismatch("dac0Data src3", 32'h2000, 32'(dac0Data));
        if (dac1Data !== 14'h2000) reportMismatch("dac1Data src3", 32'h2000, 32'(dac1Data));
        finishTest();
    endtask

    task automatic testOverflow();
        busData_t value;
        startTest("overflow");
        busRead(regAddr(SpaceTop, OffAdcStatus), value);
        if (value !== 32'h0) reportMismatch("status before", 32'h0, value);
        @(posedge clk);
        adc0Overflow <= 1'b1;
        @(posedge clk);
        adc0Overflow <= 1'b0;
        busRead(regAddr(SpaceTop, OffAdcStatus), value);
        if (value !== 32'h1) reportMismatch("status set", 32'h1, value);
        busWrite(regAddr(SpaceTop, OffAdcStatus), 32'h1, 4'b0001);
        busRead(regAddr(SpaceTop, OffAdcStatus), value);
        if (value !== 32'h0) reportMismatch("status cleared", 32'h0, value);
        finishTest();
    endtask

    task automatic testVideoSwitch();
        vidSelect_t code0;
        vidSelect_t code1;
        busData_t   value;
        startTest("videoSwitch");
        for (int c = 0; c < 4; c++) begin
            code0 = 2'(c);
            code1 = 2'(3 - c);
            busWrite(regAddr(SpaceVideo, OffVid0), 32'(code0), 4'b0001);
            busWrite(regAddr(SpaceVideo, OffVid1), 32'(code1), 4'b0001);
            @(negedge clk);
            if (video0InSelect !== code0) begin
                reportMismatch("video0InSelect", 32'(code0), 32'(video0InSelect));
            end
            if (video0OutSelect !== swapCode(code0)) begin
                reportMismatch("video0OutSelect", 32'(swapCode(code0)), 32'(video0OutSelect));
            end
            if (video1InSelect !== code1) begin
                reportMismatch("video1InSelect", 32'(code1), 32'(video1InSelect));
            end
            if (video1OutSelect !== swapCode(code1)) begin
                reportMismatch("video1OutSelect", 32'(swapCode(code1)), 32'(video1OutSelect));
            end
            busRead(regAddr(SpaceVideo, OffVid0), value);
            if (value !== 32'(code0)) reportMismatch("vid0 readback", 32'(code0), value);
            busRead(regAddr(SpaceVideo, OffVid1), value);
            if (value !== 32'(code1)) reportMismatch("vid1 readback", 32'(code1), value);
        end
        finishTest();
    endtask

    // ************************************************************************
    // Main sequence
    // ************************************************************************

    initial begin
        rst          = 1'b1;
        bus          = '0;
        adc0         = '0;
        adc0Overflow = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        testResetState();
        testTopRegs();
        testAdcPath();
        testTestSource();
        testOverflow();
        testVideoSwitch();

        if (UUT.uChecks.failCount != 0) begin
            $display("Bound assertions failed %0d times", UUT.uChecks.failCount);
            totalErrors += UUT.uChecks.failCount;
        end
        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 testsRun, testsFailed, totalErrors);
        if (totalErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: stcIoTop.f
stcIoPkg.sv
regDecode.sv
topRegs.sv
adcFrontEnd.sv
dacRegs.sv
dacChannel.sv
videoSwitch.sv
stcIoTop.sv
stcIoTop_assertions.sv
stcIoTop_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= stcIoTop_tb
FILELIST  ?= stcIoTop.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIMARGS   ?= +verilator+error+limit+100

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIMARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed!" $(LOG); then echo "Simulation gave no result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
